// File: common/vita_rx_macros.svh
`ifndef VITA_RX_MACROS_SVH
`define VITA_RX_MACROS_SVH

// Sizing
`define VITA_MAXCHAN      4      // Max channels per sample
`define VITA_FIFO_DEPTH   16     // Output FIFO entries
`define VITA_AXIL_AW      5      // AXI4-Lite address bits

// Register map, byte offsets
`define VITA_REG_CTRL     5'h00  // Bit 0 written as 1 clears
`define VITA_REG_HEADER   5'h04
`define VITA_REG_STREAMID 5'h08
`define VITA_REG_TRAILER  5'h0C
`define VITA_REG_SPP      5'h10  // Samples per packet
`define VITA_REG_NUMCHAN  5'h14
`define VITA_REG_STATUS   5'h18  // FIFO occupancy, read-only

`endif

// File: common/vita_rx_pkg.sv
`default_nettype none

package vita_rx_pkg;

`include "vita_rx_macros.svh"

   typedef logic [31:0] vita_word_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [3:0]  sample_flags_t;   // Bit 0 end of burst, bits 3..1 errors
   typedef logic [15:0] sample_count_t;
   typedef logic [3:0]  pkt_count_t;
   typedef logic [1:0]  chan_idx_t;
   typedef logic [`VITA_AXIL_AW-1:0] axil_addr_t;
   typedef logic [$clog2(`VITA_FIFO_DEPTH+1)-1:0] fifo_count_t;

   // One timestamped sample, channel 0 in the low word
   typedef struct packed {
      sample_flags_t                  flags;
      vita_time_t                     timestamp;
      vita_word_t [`VITA_MAXCHAN-1:0] chan;
   } sample_beat_t;

   typedef struct packed {
      logic       sop;
      logic       eop;
      vita_word_t data;
   } pkt_line_t;

   typedef struct packed {
      vita_word_t    header;
      vita_word_t    streamid;
      vita_word_t    trailer;
      sample_count_t spp;
      logic [2:0]    numchan;
   } framer_cfg_t;

   typedef struct packed {
      axil_addr_t awaddr;
      logic       awvalid;
      vita_word_t wdata;
      logic [3:0] wstrb;
      logic       wvalid;
      logic       bready;
      axil_addr_t araddr;
      logic       arvalid;
      logic       rready;
   } axil_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
      logic       arready;
      vita_word_t rdata;
      logic [1:0] rresp;
      logic       rvalid;
   } axil_rsp_t;

   typedef enum logic [3:0] {
      IDLE, HEADER, STREAMID, SECS, TICS, TICS2, PAYLOAD, TRAILER,
      ERR_HEADER, ERR_STREAMID, ERR_SECS, ERR_TICS, ERR_TICS2, ERR_PAYLOAD
   } framer_state_e;

endpackage

`default_nettype wire

// File: rtl/vita_rx_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "vita_rx_macros.svh"

module vita_rx_regs import vita_rx_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire axil_req_t   axil_req_i,
   output axil_rsp_t        axil_rsp_o,
   input  wire fifo_count_t occupancy_i,
   output framer_cfg_t      cfg_o,
   output logic             clear_o,
   output logic             streamid_wr_o
);

   framer_cfg_t cfg_q;
   logic        aw_held_q, w_held_q, bvalid_q, rvalid_q;
   axil_addr_t  aw_addr_q;
   vita_word_t  w_data_q;
   logic [3:0]  w_strb_q;
   vita_word_t  rdata_q;
   logic        awready, wready, arready;
   logic        aw_fire, w_fire, ar_fire, do_write;
   axil_addr_t  wr_addr;
   vita_word_t  wr_word;

   function automatic vita_word_t reg_value(axil_addr_t a, framer_cfg_t c, fifo_count_t occ);
      case (a)
         `VITA_REG_HEADER:   return c.header;
         `VITA_REG_STREAMID: return c.streamid;
         `VITA_REG_TRAILER:  return c.trailer;
         `VITA_REG_SPP:      return 32'(c.spp);
         `VITA_REG_NUMCHAN:  return 32'(c.numchan);
         `VITA_REG_STATUS:   return 32'(occ);
         default:            return '0;  // CTRL and holes read 0
      endcase
   endfunction

   // Byte lanes not strobed keep the old value
   function automatic vita_word_t merge_strb(vita_word_t old_v, vita_word_t new_v,
                                             logic [3:0] strb);
      vita_word_t res;
      for (int i = 0; i < 4; i++)
      begin
         res[8*i +: 8] = strb[i] ? new_v[8*i +: 8] : old_v[8*i +: 8];
      end
      return res;
   endfunction

   function automatic logic [2:0] clamp_numchan(vita_word_t v);
      if (v == '0)
         return 3'd1;
      else if (v > `VITA_MAXCHAN)
         return 3'(`VITA_MAXCHAN);
      else
         return v[2:0];
   endfunction

   // No new write is taken while a response is pending
   assign awready  = !aw_held_q && !bvalid_q;
   assign wready   = !w_held_q && !bvalid_q;
   assign arready  = !rvalid_q;
   assign aw_fire  = axil_req_i.awvalid && awready;
   assign w_fire   = axil_req_i.wvalid && wready;
   assign ar_fire  = axil_req_i.arvalid && arready;
   assign do_write = (aw_held_q || aw_fire) && (w_held_q || w_fire);
   assign wr_addr  = aw_held_q ? aw_addr_q : axil_req_i.awaddr;
   assign wr_word  = merge_strb(reg_value(wr_addr, cfg_q, occupancy_i),
                                w_held_q ? w_data_q : axil_req_i.wdata,
                                w_held_q ? w_strb_q : axil_req_i.wstrb);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         aw_held_q     <= 1'b0;
         w_held_q      <= 1'b0;
         bvalid_q      <= 1'b0;
         rvalid_q      <= 1'b0;
         clear_o       <= 1'b0;
         streamid_wr_o <= 1'b0;
         cfg_q         <= '0;
         cfg_q.numchan <= 3'd1;
      end
      else
      begin
         clear_o       <= do_write && wr_addr == `VITA_REG_CTRL && wr_word[0];
         streamid_wr_o <= do_write && wr_addr == `VITA_REG_STREAMID;
         if (do_write)
         begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            bvalid_q  <= 1'b1;
            case (wr_addr)
               `VITA_REG_HEADER:   cfg_q.header   <= wr_word;
               `VITA_REG_STREAMID: cfg_q.streamid <= wr_word;
               `VITA_REG_TRAILER:  cfg_q.trailer  <= wr_word;
               `VITA_REG_SPP:      cfg_q.spp      <= wr_word[15:0];
               `VITA_REG_NUMCHAN:  cfg_q.numchan  <= clamp_numchan(wr_word);
               default:            ;
            endcase
         end
         else
         begin
            if (aw_fire) aw_held_q <= 1'b1;  // Half of a write, wait for the other
            if (w_fire)  w_held_q  <= 1'b1;
            if (bvalid_q && axil_req_i.bready) bvalid_q <= 1'b0;
         end
         if (ar_fire)
            rvalid_q <= 1'b1;
         else if (axil_req_i.rready)
            rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_fire) aw_addr_q <= axil_req_i.awaddr;
      if (w_fire)
      begin
         w_data_q <= axil_req_i.wdata;
         w_strb_q <= axil_req_i.wstrb;
      end
      if (ar_fire) rdata_q <= reg_value(axil_req_i.araddr, cfg_q, occupancy_i);
   end

   assign axil_rsp_o = '{awready: awready, wready: wready, bvalid: bvalid_q, bresp: 2'b00,
                         arready: arready, rdata: rdata_q, rresp: 2'b00, rvalid: rvalid_q};
   assign cfg_o = cfg_q;

   // Channel count must stay usable by the sequencer
   numchan_in_range: assert property (@(posedge clk) disable iff (reset)
      cfg_q.numchan inside {[1:`VITA_MAXCHAN]});

endmodule

`default_nettype wire

// File: vita_rx_framer/vita_sample_seq.sv
`timescale 1ns/100ps
`default_nettype none

module vita_sample_seq import vita_rx_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         reset,
   input  wire sample_beat_t sample_i,
   input  wire framer_cfg_t  cfg_i,
   input  wire logic         start_i,
   input  wire logic         advance_i,
   output vita_word_t        chan_word_o,
   output logic              last_chan_o,
   output logic              last_sample_o
);

   chan_idx_t     phase_q;    // Channel within the current sample
   sample_count_t sample_q;   // Sample within the packet, from 1

   always_ff @(posedge clk)
   begin
      if (reset || start_i)
      begin
         phase_q  <= '0;
         sample_q <= sample_count_t'(1);
      end
      else if (advance_i)
      begin
         if (last_chan_o)
         begin
            phase_q  <= '0;
            sample_q <= sample_q + 1'b1;
         end
         else
         begin
            phase_q <= phase_q + 1'b1;
         end
      end
   end

   assign last_chan_o   = {1'b0, phase_q} == cfg_i.numchan - 3'd1;
   assign last_sample_o = sample_q == cfg_i.spp;
   assign chan_word_o   = sample_i.chan[phase_q];

endmodule

`default_nettype wire

// File: vita_rx_framer/vita_rx_framer.sv
`timescale 1ns/100ps
`default_nettype none

module vita_rx_framer import vita_rx_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         reset,
   input  wire logic         clear_i,
   input  wire logic         streamid_wr_i,
   input  wire framer_cfg_t  cfg_i,
   input  wire sample_beat_t sample_i,
   input  wire logic         sample_valid_i,
   output logic              sample_ready_o,
   input  wire vita_word_t   chan_word_i,
   input  wire logic         last_chan_i,
   input  wire logic         last_sample_i,
   output logic              seq_start_o,
   output logic              seq_advance_o,
   output pkt_line_t         wr_line_o,
   output logic              wr_valid_o,
   input  wire logic         wr_ready_i
);

   framer_state_e state_q, state_d;
   pkt_count_t    pkt_count_q;
   logic          trl_eob_q;
   logic          has_sid;
   logic          err_sample;   // Sample needing an error packet
   logic          pay_wr;       // Payload word offered this cycle
   sample_count_t pay_len;
   sample_count_t pkt_len;

   assign has_sid    = cfg_i.header[28];
   assign err_sample = sample_valid_i && |sample_i.flags[3:1];
   assign pay_wr     = state_q == PAYLOAD && sample_valid_i && !err_sample;
   assign pay_len    = cfg_i.spp * sample_count_t'(cfg_i.numchan);
   assign pkt_len    = 16'd5 + sample_count_t'(has_sid) + pay_len;  // Nominal length

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (sample_valid_i) state_d = err_sample ? ERR_HEADER : HEADER;
         HEADER:       state_d = has_sid ? STREAMID : SECS;
         STREAMID:     state_d = SECS;
         SECS:         state_d = TICS;
         TICS:         state_d = TICS2;
         TICS2:        state_d = PAYLOAD;
         PAYLOAD:
         begin
            // Error sample stays unconsumed and gets its own packet after this one
            if (err_sample)
               state_d = TRAILER;
            else if (pay_wr && last_chan_i && (last_sample_i || |sample_i.flags))
               state_d = TRAILER;
         end
         TRAILER:      state_d = IDLE;
         ERR_HEADER:   state_d = ERR_STREAMID;
         ERR_STREAMID: state_d = ERR_SECS;
         ERR_SECS:     state_d = ERR_TICS;
         ERR_TICS:     state_d = ERR_TICS2;
         ERR_TICS2:    state_d = ERR_PAYLOAD;
         default:      state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear_i)
      begin
         state_q   <= IDLE;
         trl_eob_q <= 1'b0;
      end
      else
      begin
         if (state_q == IDLE || wr_ready_i)
            state_q <= state_d;
         if (wr_ready_i && (err_sample || (pay_wr && last_chan_i)) && state_q == PAYLOAD)
            trl_eob_q <= sample_i.flags[0];  // Flags of the last sample taken
      end
   end

   // Only data trailers count packets
   always_ff @(posedge clk)
   begin
      if (reset || streamid_wr_i)
         pkt_count_q <= '0;
      else if (state_q == TRAILER && wr_ready_i)
         pkt_count_q <= pkt_count_q + 1'b1;
   end

   always_comb
   begin
      wr_line_o     = '0;
      wr_line_o.sop = state_q == HEADER || state_q == ERR_HEADER;
      wr_line_o.eop = state_q == TRAILER || state_q == ERR_PAYLOAD;
      case (state_q)
         HEADER:
            wr_line_o.data = {3'b000, cfg_i.header[28], 2'b01, cfg_i.header[25:20],
                              pkt_count_q, pkt_len};
         STREAMID, ERR_STREAMID:
            wr_line_o.data = cfg_i.streamid;
         SECS, ERR_SECS:
            wr_line_o.data = sample_i.timestamp[63:32];
         TICS2, ERR_TICS2:
            wr_line_o.data = sample_i.timestamp[31:0];
         PAYLOAD:
            wr_line_o.data = chan_word_i;
         TRAILER:
            wr_line_o.data = {cfg_i.trailer[31:21], 1'b1, cfg_i.trailer[19:9],
                              trl_eob_q, 8'd0};
         ERR_HEADER:
            wr_line_o.data = {4'b0101, 4'b0000, cfg_i.header[23:20], pkt_count_q, 16'd6};
         ERR_PAYLOAD:
            wr_line_o.data = {28'd0, sample_i.flags};
         default:
            wr_line_o.data = '0;  // TICS words are zero
      endcase
   end

   assign wr_valid_o     = state_q == PAYLOAD ? pay_wr : state_q != IDLE;
   assign sample_ready_o = wr_ready_i && ((pay_wr && last_chan_i) || state_q == ERR_PAYLOAD);
   assign seq_start_o    = state_q == IDLE;
   assign seq_advance_o  = pay_wr && wr_ready_i;

   idle_no_write: assert property (@(posedge clk) disable iff (reset)
      state_q == IDLE |-> !wr_valid_o);

endmodule

`default_nettype wire

// File: rtl/pkt_out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_out_fifo import vita_rx_pkg::*;
#(
   parameter int DEPTH = 16
)
(
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         clear_i,
   input  wire pkt_line_t                    wr_line_i,
   input  wire logic                         wr_valid_i,
   output logic                              wr_ready_o,
   output pkt_line_t                         rd_line_o,
   output logic                              rd_valid_o,
   input  wire logic                         rd_ready_i,
   output logic [$clog2(DEPTH+1)-1:0]        occupancy_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH+1);

   pkt_line_t          mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0]   count_q;
   logic               full, wr_fire, rd_fire;

   assign full       = count_q == CNT_W'(DEPTH);
   assign wr_ready_o = !full;
   assign rd_valid_o = count_q != '0;
   assign wr_fire    = wr_valid_i && wr_ready_o;
   assign rd_fire    = rd_valid_o && rd_ready_i;

   always_ff @(posedge clk)
   begin
      if (reset || clear_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_fire)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
         if (rd_fire)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + CNT_W'(wr_fire) - CNT_W'(rd_fire);
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire) mem[wr_ptr_q] <= wr_line_i;
   end

   assign rd_line_o   = mem[rd_ptr_q];  // Head word, visible the cycle after its write
   assign occupancy_o = count_q;

   // A full FIFO that is not drained takes no write
   no_write_when_full: assert property (@(posedge clk) disable iff (reset)
      full && !rd_fire && !clear_i |=> wr_ptr_q == $past(wr_ptr_q));

   rd_line_stable: assert property (@(posedge clk) disable iff (reset)
      rd_valid_o && !rd_ready_i && !clear_i |=> rd_valid_o && $stable(rd_line_o));

endmodule

`default_nettype wire

// File: rtl/vita_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "vita_rx_macros.svh"

module vita_rx_top import vita_rx_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         reset,
   input  wire axil_req_t    axil_req_i,
   output axil_rsp_t         axil_rsp_o,
   input  wire sample_beat_t sample_i,
   input  wire logic         sample_valid_i,
   output logic              sample_ready_o,
   output pkt_line_t         pkt_o,
   output logic              pkt_valid_o,
   input  wire logic         pkt_ready_i
);

   framer_cfg_t cfg;
   logic        clear, streamid_wr;
   fifo_count_t occupancy;
   vita_word_t  chan_word;
   logic        last_chan, last_sample, seq_start, seq_advance;
   pkt_line_t   wr_line;
   logic        wr_valid, wr_ready;

   vita_rx_regs u_regs (
      .clk(clk), .reset(reset),
      .axil_req_i(axil_req_i), .axil_rsp_o(axil_rsp_o),
      .occupancy_i(occupancy), .cfg_o(cfg),
      .clear_o(clear), .streamid_wr_o(streamid_wr));

   vita_sample_seq u_seq (
      .clk(clk), .reset(reset), .sample_i(sample_i), .cfg_i(cfg),
      .start_i(seq_start), .advance_i(seq_advance),
      .chan_word_o(chan_word), .last_chan_o(last_chan), .last_sample_o(last_sample));

   vita_rx_framer u_framer (
      .clk(clk), .reset(reset), .clear_i(clear), .streamid_wr_i(streamid_wr),
      .cfg_i(cfg), .sample_i(sample_i),
      .sample_valid_i(sample_valid_i), .sample_ready_o(sample_ready_o),
      .chan_word_i(chan_word), .last_chan_i(last_chan), .last_sample_i(last_sample),
      .seq_start_o(seq_start), .seq_advance_o(seq_advance),
      .wr_line_o(wr_line), .wr_valid_o(wr_valid), .wr_ready_i(wr_ready));

   pkt_out_fifo #(.DEPTH(`VITA_FIFO_DEPTH)) u_fifo (
      .clk(clk), .reset(reset), .clear_i(clear),
      .wr_line_i(wr_line), .wr_valid_i(wr_valid), .wr_ready_o(wr_ready),
      .rd_line_o(pkt_o), .rd_valid_o(pkt_valid_o), .rd_ready_i(pkt_ready_i),
      .occupancy_o(occupancy));

endmodule

`default_nettype wire

// File: verification/vita_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "vita_rx_macros.svh"

module vita_rx_tb import vita_rx_pkg::*; ();

   localparam int CLK_PERIOD = 100;
   // Six tests need well under 2000 cycles even with stalls, so this is a wide ceiling
   localparam int TIMEOUT_CYCLES = 20000;

   logic         clk;
   logic         reset;
   axil_req_t    axil_req;
   axil_rsp_t    axil_rsp;
   sample_beat_t sample;
   logic         sample_valid;
   logic         sample_ready;
   pkt_line_t    pkt;
   logic         pkt_valid;
   logic         pkt_ready;

   integer       seed = 32'h18b1_8f99;
   int           cycle_cnt = 0;
   bit           rand_bp = 1'b0;    // Random stalls on the packet output
   bit           hold_out = 1'b0;   // Packet output fully stalled
   pkt_line_t    exp_q[$];
   pkt_line_t    rx_q[$];
   vita_word_t   cfg_hdr, cfg_sid, cfg_trl;
   int           cfg_spp, cfg_nch;
   pkt_count_t   exp_count;         // Sequence count the next data packet should carry
   vita_time_t   next_time = 64'h0000_0042_0000_1000;
   int           sample_idx = 0;

   vita_rx_top uut (
      .clk(clk), .reset(reset),
      .axil_req_i(axil_req), .axil_rsp_o(axil_rsp),
      .sample_i(sample), .sample_valid_i(sample_valid), .sample_ready_o(sample_ready),
      .pkt_o(pkt), .pkt_valid_o(pkt_valid), .pkt_ready_i(pkt_ready));

   always #(CLK_PERIOD/2) clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("CHECKS FAILED");
         $fatal(1, "Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   // Ready changes on the falling edge, words are taken once settled before the rise
   always @(negedge clk)
   begin
      if (hold_out)
         pkt_ready = 1'b0;
      else if (rand_bp)
         pkt_ready = ($random(seed) & 3) != 0;
      else
         pkt_ready = 1'b1;
      #10;
      if (pkt_valid && pkt_ready)
         rx_q.push_back(pkt);
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   // AW and W go out together, each dropped once taken
   task automatic write_reg(input axil_addr_t addr, input vita_word_t data);
      logic aw_done, w_done;
      aw_done          = 1'b0;
      w_done           = 1'b0;
      axil_req.awaddr  = addr;
      axil_req.awvalid = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = 4'hF;
      axil_req.wvalid  = 1'b1;
      while (!(aw_done && w_done))
      begin
         #10;
         aw_done = aw_done || axil_rsp.awready;
         w_done  = w_done || axil_rsp.wready;
         @(negedge clk);
         if (aw_done) axil_req.awvalid = 1'b0;
         if (w_done)  axil_req.wvalid  = 1'b0;
      end
      #10;
      while (!axil_rsp.bvalid)
      begin
         @(negedge clk);
         #10;
      end
      check_value("bresp", 64'(axil_rsp.bresp), 64'd0);
      @(negedge clk);
   endtask

   task automatic read_reg(input axil_addr_t addr, output vita_word_t data);
      axil_req.araddr  = addr;
      axil_req.arvalid = 1'b1;
      #10;
      while (!axil_rsp.arready)
      begin
         @(negedge clk);
         #10;
      end
      @(negedge clk);
      axil_req.arvalid = 1'b0;
      #10;
      while (!axil_rsp.rvalid)
      begin
         @(negedge clk);
         #10;
      end
      data = axil_rsp.rdata;
      check_value("rresp", 64'(axil_rsp.rresp), 64'd0);
      @(negedge clk);
   endtask

   task automatic verify_reg(input string name, input axil_addr_t addr, input vita_word_t exp);
      vita_word_t got;
      read_reg(addr, got);
      check_value(name, 64'(got), 64'(exp));
   endtask

   task automatic set_config(input vita_word_t hdr, input vita_word_t trl,
                             input int spp, input int nch);
      write_reg(`VITA_REG_HEADER, hdr);
      write_reg(`VITA_REG_TRAILER, trl);
      write_reg(`VITA_REG_SPP, vita_word_t'(spp));
      write_reg(`VITA_REG_NUMCHAN, vita_word_t'(nch));
      cfg_hdr = hdr;
      cfg_trl = trl;
      cfg_spp = spp;
      cfg_nch = nch;
   endtask

   task automatic set_streamid(input vita_word_t sid);
      write_reg(`VITA_REG_STREAMID, sid);
      cfg_sid   = sid;
      exp_count = '0;
   endtask

   // Channel words tagged with channel, sample number and low time bits
   function automatic sample_beat_t make_sample(input sample_flags_t flags);
      sample_beat_t s;
      s.flags     = flags;
      s.timestamp = next_time;
      for (int c = 0; c < `VITA_MAXCHAN; c++)
         s.chan[c] = {8'hC0 + 8'(c), 8'(sample_idx), next_time[15:0]};
      next_time  = next_time + 64'd250;
      sample_idx = sample_idx + 1;
      return s;
   endfunction

   task automatic push_word(input logic sop, input logic eop, input vita_word_t data);
      exp_q.push_back({sop, eop, data});
   endtask

   task automatic data_packet_model(input sample_beat_t s[$]);
      logic [15:0] len;
      len = 16'(5 + int'(cfg_hdr[28]) + cfg_spp * cfg_nch);  // Nominal even if cut short
      push_word(1'b1, 1'b0, {3'b000, cfg_hdr[28], 2'b01, cfg_hdr[25:20], exp_count, len});
      if (cfg_hdr[28])
         push_word(1'b0, 1'b0, cfg_sid);
      push_word(1'b0, 1'b0, s[0].timestamp[63:32]);
      push_word(1'b0, 1'b0, 32'd0);
      push_word(1'b0, 1'b0, s[0].timestamp[31:0]);
      foreach (s[i])
         for (int c = 0; c < cfg_nch; c++)
            push_word(1'b0, 1'b0, s[i].chan[c]);
      push_word(1'b0, 1'b1, {cfg_trl[31:21], 1'b1, cfg_trl[19:9], s[$].flags[0], 8'd0});
      exp_count = exp_count + 1'b1;
   endtask

   task automatic error_packet_model(input sample_beat_t s);
      push_word(1'b1, 1'b0, {4'b0101, 4'b0000, cfg_hdr[23:20], exp_count, 16'd6});
      push_word(1'b0, 1'b0, cfg_sid);
      push_word(1'b0, 1'b0, s.timestamp[63:32]);
      push_word(1'b0, 1'b0, 32'd0);
      push_word(1'b0, 1'b0, s.timestamp[31:0]);
      push_word(1'b0, 1'b1, {28'd0, s.flags});
   endtask

   // Called on a falling edge, returns on the falling edge after the transfer
   task automatic send_sample(input sample_beat_t s);
      sample       = s;
      sample_valid = 1'b1;
      #10;
      while (!sample_ready)
      begin
         @(negedge clk);
         #10;
      end
      @(negedge clk);
   endtask

   task automatic send_packet(input sample_beat_t s[$]);
      foreach (s[i])
         send_sample(s[i]);
      sample_valid = 1'b0;
   endtask

   task automatic compare_packets();
      while (rx_q.size() < exp_q.size())
         @(negedge clk);
      check_value("packet word count", 64'(rx_q.size()), 64'(exp_q.size()));
      foreach (exp_q[i])
         check_value($sformatf("pkt_o word %0d", i), 64'(rx_q[i]), 64'(exp_q[i]));
      check_value("pkt_valid_o", 64'(pkt_valid), 64'd0);   // Nothing left behind
      rx_q.delete();
      exp_q.delete();
   endtask

   task automatic register_access();
      verify_reg("NUMCHAN", `VITA_REG_NUMCHAN, 32'd1);
      verify_reg("STATUS", `VITA_REG_STATUS, 32'd0);
      write_reg(`VITA_REG_HEADER, 32'h1230_0000);
      verify_reg("HEADER", `VITA_REG_HEADER, 32'h1230_0000);
      write_reg(`VITA_REG_TRAILER, 32'hA5C3_5E00);
      verify_reg("TRAILER", `VITA_REG_TRAILER, 32'hA5C3_5E00);
      write_reg(`VITA_REG_SPP, 32'd4);
      verify_reg("SPP", `VITA_REG_SPP, 32'd4);
      write_reg(`VITA_REG_NUMCHAN, 32'd7);
      verify_reg("NUMCHAN", `VITA_REG_NUMCHAN, 32'd4);  // Clamped to the maximum
      set_streamid(32'hCAFE_0001);
      verify_reg("STREAMID", `VITA_REG_STREAMID, 32'hCAFE_0001);
   endtask

   task automatic single_channel_packet();
      sample_beat_t s[$];
      set_config(32'h1230_0000, 32'hA5C3_5E00, 4, 1);
      for (int i = 0; i < 4; i++)
         s.push_back(make_sample(4'h0));
      data_packet_model(s);
      send_packet(s);
      compare_packets();
   endtask

   task automatic multi_channel_backpressure();
      sample_beat_t s[$];
      set_config(32'h0150_0000, 32'h0F0F_F0F0, 2, 3);
      rand_bp = 1'b1;
      for (int p = 0; p < 3; p++)
      begin
         s.delete();
         s.push_back(make_sample(4'h0));
         s.push_back(make_sample(4'h0));
         data_packet_model(s);
         send_packet(s);
      end
      compare_packets();
      rand_bp = 1'b0;
   endtask

   task automatic early_end_packet();
      sample_beat_t s[$];
      set_config(32'h1230_0000, 32'hA5C3_5E00, 4, 2);
      s.push_back(make_sample(4'h0));
      s.push_back(make_sample(4'h1));   // End of burst after two of four samples
      data_packet_model(s);
      send_packet(s);
      compare_packets();
   endtask

   task automatic error_packet();
      sample_beat_t s[$];
      s.push_back(make_sample(4'b0100));
      error_packet_model(s[0]);
      send_packet(s);
      compare_packets();
      s.delete();
      for (int i = 0; i < 4; i++)
         s.push_back(make_sample(4'h0));
      data_packet_model(s);   // Same count as before the error packet
      send_packet(s);
      compare_packets();
   endtask

   task automatic clear_and_count_reset();
      sample_beat_t s[$];
      vita_word_t   status;
      set_streamid(32'hBEEF_0002);
      set_config(32'h1230_0000, 32'hA5C3_5E00, 2, 1);
      s.push_back(make_sample(4'h0));
      s.push_back(make_sample(4'h0));
      data_packet_model(s);
      send_packet(s);
      compare_packets();
      hold_out = 1'b1;
      s.delete();
      s.push_back(make_sample(4'h0));
      s.push_back(make_sample(4'h0));
      data_packet_model(s);
      send_packet(s);
      status = '0;
      while (status != 32'(exp_q.size()))   // Whole packet parked in the FIFO
         read_reg(`VITA_REG_STATUS, status);
      check_value("pkt_valid_o", 64'(pkt_valid), 64'd1);
      write_reg(`VITA_REG_CTRL, 32'd1);
      verify_reg("STATUS", `VITA_REG_STATUS, 32'd0);
      check_value("pkt_valid_o", 64'(pkt_valid), 64'd0);
      exp_q.delete();
      hold_out = 1'b0;
      s.delete();
      s.push_back(make_sample(4'h0));
      s.push_back(make_sample(4'h0));
      data_packet_model(s);
      send_packet(s);
      compare_packets();
   endtask

   initial
   begin
      clk             = 1'b0;
      reset           = 1'b1;
      axil_req        = '0;
      axil_req.bready = 1'b1;
      axil_req.rready = 1'b1;
      sample          = '0;
      sample_valid    = 1'b0;
      pkt_ready       = 1'b0;
      cfg_hdr         = '0;
      cfg_sid         = '0;
      cfg_trl         = '0;
      cfg_spp         = 0;
      cfg_nch         = 1;
      exp_count       = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      register_access();
      single_channel_packet();
      multi_channel_backpressure();
      early_end_packet();
      error_packet();
      clear_and_count_reset();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vita_rx.f
+incdir+common
common/vita_rx_pkg.sv
rtl/vita_rx_regs.sv
vita_rx_framer/vita_sample_seq.sv
vita_rx_framer/vita_rx_framer.sv
rtl/pkt_out_fifo.sv
rtl/vita_rx_top.sv
verification/vita_rx_tb.sv

// File: Makefile
# Verilator build and run of the vita_rx testbench

VERILATOR ?= verilator
TOP       ?= vita_rx_tb
FILELIST  ?= vita_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) common/vita_rx_macros.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
